/* console_to_video.f */
+incdir+logic
logic/c2v_pkg.sv
logic/raster_timing.sv
logic/line_ring_buffer.sv
logic/dot_capture.sv
logic/scale3_readout.sv
logic/frame_sync.sv
logic/audio_pacer.sv
logic/console_to_video.sv
verification/console_to_video_checker.sv
verification/console_to_video_tb.sv

/* Makefile */
TOP := console_to_video_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): console_to_video.f $(wildcard logic/*.sv logic/*.svh verification/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f console_to_video.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f console_to_video.f

clean:
	rm -rf obj_dir

/* verification/console_to_video_tb.sv */
/* testbench for the console to 720p bridge
   fills the line ring, then checks scaling, overlay, frame sync and audio */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module console_to_video_tb;

    typedef struct packed {
        logic [7:0]       line;
        logic             ovl;
        c2v_pkg::rgb15_t  ovl_color;
        c2v_pkg::stereo_t pair;
    } step_t;

    logic                  clk_pixel;
    logic                  resetn;
    c2v_pkg::console_dot_t dot;
    logic                  snes_refresh;
    logic                  overlay;
    c2v_pkg::rgb15_t       overlay_color;
    c2v_pkg::stereo_t      audio_in;
    logic                  audio_ready;
    c2v_pkg::raster_pos_t  overlay_pos;
    c2v_pkg::rgb24_t       rgb;
    logic                  audio_en;
    c2v_pkg::stereo_t      audio_out;
    logic                  audio_strobe;
    logic                  clk_audio;
    logic                  pause_console;

    step_t           steps [0:4];
    c2v_pkg::rgb15_t ref_pix [0:15][0:255];
    logic [31:0]     lcg_state;

    console_to_video dut (
        .clk_pixel     (clk_pixel),
        .resetn        (resetn),
        .dot           (dot),
        .snes_refresh  (snes_refresh),
        .overlay       (overlay),
        .overlay_color (overlay_color),
        .audio_in      (audio_in),
        .audio_ready   (audio_ready),
        .overlay_pos   (overlay_pos),
        .rgb           (rgb),
        .audio_en      (audio_en),
        .audio_out     (audio_out),
        .audio_strobe  (audio_strobe),
        .clk_audio     (clk_audio),
        .pause_console (pause_console)
    );

    initial clk_pixel = 1'b0;
    always #50 clk_pixel = ~clk_pixel;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one step of the raster scan, column wraps into the next line, line wraps to 0
    function automatic c2v_pkg::raster_pos_t next_pos(input c2v_pkg::raster_pos_t p);
        c2v_pkg::raster_pos_t q;
        q = p;
        if (int'(p.x) == `C2V_TOTAL_W - 1) begin
            q.x = '0;
            if (int'(p.y) == `C2V_TOTAL_H - 1) begin
                q.y = '0;
            end else begin
                q.y = p.y + 10'd1;
            end
        end else begin
            q.x = p.x + 11'd1;
        end
        return q;
    endfunction

    // grey outside, else the source colour with 5-bit channels widened to 8
    function automatic c2v_pkg::rgb24_t expected_rgb(input int x, input int y,
                                                     input logic ovl,
                                                     input c2v_pkg::rgb15_t ocol);
        c2v_pkg::rgb15_t src;
        logic [4:0]      r;
        logic [4:0]      g;
        logic [4:0]      b;
        if (x < `C2V_PIC_X0 || x >= `C2V_PIC_X1 || y < `C2V_PIC_Y0 || y >= `C2V_PIC_Y1) begin
            return `C2V_BORDER;
        end
        src = ovl ? ocol : ref_pix[((y - `C2V_PIC_Y0) / 3) % 16][(x - `C2V_PIC_X0) / 3];
        r = src[4:0];
        g = src[9:5];
        b = src[14:10];
        return {r, 3'b000, g, 3'b000, b, 3'b000};
    endfunction

    task automatic tick();
        @(posedge clk_pixel);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("[ERROR] %s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // one strobe per pixel, xs counts half dots
    task automatic write_lines();
        for (int l = 0; l < 16; l++) begin
            for (int p = 0; p < 256; p++) begin
                lcg_state = lcg_next(lcg_state);
                ref_pix[l][p] = lcg_state[30:16];
                dot.ys = 9'(l);
                dot.xs = 9'(p * 2);
                dot.color = lcg_state[30:16];
                dot.strobe = 1'b1;
                tick();
                dot.strobe = 1'b0;
                tick();
            end
        end
        dot.ys = 9'd50;
    endtask

    task automatic wait_for_pos(input int x, input int y);
        int n;
        n = 0;
        while (!(overlay_pos.x == 11'(x) && overlay_pos.y == 10'(y))) begin
            tick();
            n++;
            if (n > `C2V_TOTAL_W * `C2V_TOTAL_H + 10) begin
                abort_run("raster never reached the requested position");
            end
        end
    endtask

    // rgb after a tick belongs to the position seen two ticks before
    task automatic check_span(input string name, input int cycles, input logic ovl,
                              input c2v_pkg::rgb15_t ocol);
        c2v_pkg::raster_pos_t p2;
        c2v_pkg::raster_pos_t p1;
        c2v_pkg::raster_pos_t p0;
        c2v_pkg::rgb24_t      exp;
        p0 = overlay_pos;
        p1 = p0;
        for (int i = 0; i < cycles; i++) begin
            tick();
            p2 = p1;
            p1 = p0;
            p0 = overlay_pos;
            assert (p0 == next_pos(p1))
                else report_mismatch("raster_step", 32'(next_pos(p1)), 32'(p0));
            if (i >= 1) begin
                exp = expected_rgb(int'(p2.x), int'(p2.y), ovl, ocol);
                assert (rgb == exp) else report_mismatch(name, 32'(exp), 32'(rgb));
            end
        end
    endtask

    task automatic wait_for_strobe(output int n);
        n = 0;
        do begin
            tick();
            n++;
            if (n > 2 * `C2V_AUDIO_IN_DIV + 10) begin
                abort_run("no audio_strobe while samples were waiting");
            end
        end while (!audio_strobe);
    endtask

    task automatic check_frame_sync();
        int n;
        dot.ys = 9'd2;
        snes_refresh = 1'b1;
        tick();
        snes_refresh = 1'b0;
        dot.ys = 9'd50;
        n = 0;
        while (!pause_console) begin
            tick();
            n++;
            if (n > 10) abort_run("pause_console did not rise after line 2");
        end
        n = 0;
        while (pause_console) begin
            tick();
            n++;
            if (n > 2 * `C2V_TOTAL_W * `C2V_TOTAL_H) abort_run("pause_console never fell");
        end
        assert (overlay_pos.y == 10'(`C2V_PIC_Y0))
            else report_mismatch("sync_release_line", `C2V_PIC_Y0, 32'(overlay_pos.y));
        // done state ignores line 2 until line 200 re-arms it
        dot.ys = 9'd2;
        snes_refresh = 1'b1;
        for (int i = 0; i < 20; i++) begin
            tick();
            assert (!pause_console) else report_mismatch("sync_done_hold", 0, 1);
        end
        snes_refresh = 1'b0;
        dot.ys = 9'd200;
        tick();
        dot.ys = 9'd2;
        snes_refresh = 1'b1;
        tick();
        snes_refresh = 1'b0;
        dot.ys = 9'd50;
        n = 0;
        while (!pause_console) begin
            tick();
            n++;
            if (n > 10) abort_run("pause_console did not rise after re-arm on line 200");
        end
    endtask

    task automatic check_audio();
        int n;
        // prime push aligns the pushes just after a release tick
        audio_in = 32'h0bad_cafe;
        audio_ready = 1'b1;
        tick();
        audio_ready = 1'b0;
        wait_for_strobe(n);
        assert (audio_out == 32'h0bad_cafe)
            else report_mismatch("audio_prime", 32'h0bad_cafe, audio_out);
        for (int i = 0; i < 5; i++) begin
            audio_in = steps[i].pair;
            audio_ready = 1'b1;
            tick();
            assert (audio_en == (i < 3)) else report_mismatch("audio_en", 32'(i < 3), 32'(audio_en));
        end
        audio_ready = 1'b0;
        for (int k = 0; k < 4; k++) begin
            wait_for_strobe(n);
            assert (audio_out == steps[k].pair)
                else report_mismatch("audio_order", steps[k].pair, audio_out);
            if (k > 0) begin
                assert (n >= `C2V_AUDIO_IN_DIV)
                    else report_mismatch("audio_spacing", `C2V_AUDIO_IN_DIV, 32'(n));
            end
        end
        // the fifth pair was dropped while full
        for (int i = 0; i < `C2V_AUDIO_IN_DIV + 80; i++) begin
            tick();
            assert (!audio_strobe) else report_mismatch("audio_drop", 0, audio_out);
        end
    endtask

    task automatic check_audio_clock();
        int   n;
        logic lvl;
        lvl = clk_audio;
        n = 0;
        while (clk_audio == lvl) begin
            tick();
            n++;
            if (n > 2 * `C2V_AUDIO_OUT_HALF) abort_run("clk_audio does not toggle");
        end
        lvl = clk_audio;
        n = 0;
        while (clk_audio == lvl) begin
            tick();
            n++;
            if (n > 2 * `C2V_AUDIO_OUT_HALF) abort_run("clk_audio stuck after first edge");
        end
        assert (n == `C2V_AUDIO_OUT_HALF)
            else report_mismatch("audio_clock_half", `C2V_AUDIO_OUT_HALF, 32'(n));
    endtask

    initial begin
        // console line, overlay on/off, overlay colour, audio pair
        steps[0] = '{8'd0,   1'b0, 15'h0000, 32'h1111_aaaa};
        steps[1] = '{8'd5,   1'b0, 15'h0000, 32'h2222_bbbb};
        steps[2] = '{8'd17,  1'b1, 15'h7c1f, 32'h3333_cccc};
        steps[3] = '{8'd100, 1'b1, 15'h03e0, 32'h4444_dddd};
        steps[4] = '{8'd223, 1'b0, 15'h0000, 32'h5555_eeee};
        lcg_state = 32'h8d9a_ec5c;
        resetn = 1'b1;
        dot = '0;
        snes_refresh = 1'b0;
        overlay = 1'b0;
        overlay_color = '0;
        audio_in = '0;
        audio_ready = 1'b0;
        repeat (16) @(posedge clk_pixel);
        #1;
        assert (rgb == '0 && !pause_console && !audio_strobe && !clk_audio &&
                audio_out == '0 && overlay_pos == '0)
            else abort_run("outputs not cleared by reset");
        assert (audio_en) else abort_run("audio_en low after reset");
        resetn = 1'b0;

        write_lines();
        for (int i = 0; i < 5; i++) begin
            overlay = steps[i].ovl;
            overlay_color = steps[i].ovl_color;
            // start one raster line early so the border above is covered
            wait_for_pos(0, `C2V_PIC_Y0 + 3 * int'(steps[i].line) - 1);
            check_span(steps[i].ovl ? "overlay" : "scaling", 4 * `C2V_TOTAL_W,
                       steps[i].ovl, steps[i].ovl_color);
        end
        overlay = 1'b0;

        check_frame_sync();
        check_audio();
        check_audio_clock();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/console_to_video_checker.sv */
/* protocol assertions on the bridge top level
   attached to every console_to_video instance through bind */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module console_to_video_checker (
    input wire                  clk_pixel,
    input wire                  resetn,
    input c2v_pkg::raster_pos_t overlay_pos,
    input c2v_pkg::rgb24_t      rgb,
    input wire                  pause_console,
    input wire                  audio_strobe
);

    logic in_window;
    logic first_span;

    assign in_window = (overlay_pos.x >= 11'(`C2V_PIC_X0)) &&
                       (overlay_pos.x < 11'(`C2V_PIC_X1)) &&
                       (overlay_pos.y >= 10'(`C2V_PIC_Y0)) &&
                       (overlay_pos.y < 10'(`C2V_PIC_Y1));

    // first 100 columns of the first picture line
    assign first_span = (overlay_pos.y == 10'(`C2V_PIC_Y0)) &&
                        (overlay_pos.x >= 11'(`C2V_PIC_X0)) &&
                        (overlay_pos.x < 11'(`C2V_PIC_X0 + 100));

    strobe_one_cycle: assert property (
        @(posedge clk_pixel) disable iff (resetn)
        audio_strobe |=> !audio_strobe
    ) else $error("audio_strobe stayed high for more than one cycle");

    // flag is registered, so the position is two samples back
    pause_release: assert property (
        @(posedge clk_pixel) disable iff (resetn)
        $fell(pause_console) |-> $past(first_span, 2)
    ) else $error("pause_console fell away from the first picture line");

    border_grey: assert property (
        @(posedge clk_pixel) disable iff (resetn)
        !in_window |-> ##2 (rgb == `C2V_BORDER)
    ) else $error("rgb outside the picture window is not the border grey");

endmodule

bind console_to_video console_to_video_checker chk (
    .clk_pixel     (clk_pixel),
    .resetn        (resetn),
    .overlay_pos   (overlay_pos),
    .rgb           (rgb),
    .pause_console (pause_console),
    .audio_strobe  (audio_strobe)
);

`default_nettype wire

/* logic/console_to_video.sv */
/* console video and audio to 720p rgb and sample streams
   top level, drives the rgb and audio inputs of an HDMI encoder */
`timescale 1ns/10ps
`default_nettype none

module console_to_video (
    input  wire                   clk_pixel,
    input  wire                   resetn,
    input  c2v_pkg::console_dot_t dot,
    input  wire                   snes_refresh,
    input  wire                   overlay,
    input  c2v_pkg::rgb15_t       overlay_color,
    input  c2v_pkg::stereo_t      audio_in,
    input  wire                   audio_ready,
    output c2v_pkg::raster_pos_t  overlay_pos,
    output c2v_pkg::rgb24_t       rgb,
    output logic                  audio_en,
    output c2v_pkg::stereo_t      audio_out,
    output logic                  audio_strobe,
    output logic                  clk_audio,
    output logic                  pause_console
);

    c2v_pkg::raster_pos_t pos;
    logic                 wr_en;
    c2v_pkg::buf_addr_t   wr_addr;
    c2v_pkg::rgb15_t      wr_data;
    c2v_pkg::buf_addr_t   rd_addr;
    c2v_pkg::rgb15_t      rd_data;

    raster_timing u_raster (
        .clk_pixel (clk_pixel),
        .resetn    (resetn),
        .pos       (pos)
    );

    // raw raster position for the external overlay source
    assign overlay_pos = pos;

    dot_capture u_capture (
        .clk_pixel (clk_pixel),
        .resetn    (resetn),
        .dot       (dot),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    line_ring_buffer u_buffer (
        .clk_pixel (clk_pixel),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    scale3_readout u_readout (
        .clk_pixel     (clk_pixel),
        .resetn        (resetn),
        .pos           (pos),
        .rd_data       (rd_data),
        .overlay       (overlay),
        .overlay_color (overlay_color),
        .rd_addr       (rd_addr),
        .rgb           (rgb)
    );

    frame_sync u_sync (
        .clk_pixel     (clk_pixel),
        .resetn        (resetn),
        .pos           (pos),
        .console_line  (dot.ys),
        .snes_refresh  (snes_refresh),
        .pause_console (pause_console)
    );

    audio_pacer u_audio (
        .clk_pixel    (clk_pixel),
        .resetn       (resetn),
        .audio_in     (audio_in),
        .audio_ready  (audio_ready),
        .audio_en     (audio_en),
        .audio_out    (audio_out),
        .audio_strobe (audio_strobe),
        .clk_audio    (clk_audio)
    );

endmodule

`default_nettype wire

/* logic/audio_pacer.sv */
/* stereo sample FIFO released at ~32 kHz plus the 48 kHz audio clock
   feeds the sample and clock inputs of the downstream HDMI core */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module audio_pacer (
    input  wire              clk_pixel,
    input  wire              resetn,
    input  c2v_pkg::stereo_t audio_in,
    input  wire              audio_ready,
    output logic             audio_en,
    output c2v_pkg::stereo_t audio_out,
    output logic             audio_strobe,
    output logic             clk_audio
);

    localparam int depth     = 1 << `C2V_FIFO_LOG2;
    localparam int ptr_w     = `C2V_FIFO_LOG2 + 1;
    localparam int in_div_w  = $clog2(`C2V_AUDIO_IN_DIV);
    localparam int out_div_w = $clog2(`C2V_AUDIO_OUT_HALF);

    c2v_pkg::stereo_t       fifo_mem [0:depth-1];
    // one extra bit tells full from empty
    logic [`C2V_FIFO_LOG2:0] wr_ptr;
    logic [`C2V_FIFO_LOG2:0] rd_ptr;
    logic                    full;
    logic                    empty;
    logic                    push;
    logic                    release_tick;
    logic [in_div_w-1:0]     in_div;
    logic [out_div_w-1:0]    out_div;
    logic                    out_wrap;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[`C2V_FIFO_LOG2] != rd_ptr[`C2V_FIFO_LOG2]) &&
                   (wr_ptr[`C2V_FIFO_LOG2-1:0] == rd_ptr[`C2V_FIFO_LOG2-1:0]);

    // console is told to stop before a push would be lost
    assign audio_en = ~full;
    assign push     = audio_ready & ~full;

    always_ff @(posedge clk_pixel) begin
        if (push) begin
            fifo_mem[wr_ptr[`C2V_FIFO_LOG2-1:0]] <= audio_in;
        end
    end

    assign release_tick = (in_div == in_div_w'(`C2V_AUDIO_IN_DIV - 1));

    // release divider, pops one pair per wrap when available
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            in_div       <= '0;
            audio_strobe <= 1'b0;
            audio_out    <= '0;
        end else begin
            audio_strobe <= 1'b0;
            in_div       <= release_tick ? '0 : in_div + in_div_w'(1);
            if (push) begin
                wr_ptr <= wr_ptr + ptr_w'(1);
            end
            if (release_tick && !empty) begin
                audio_out    <= fifo_mem[rd_ptr[`C2V_FIFO_LOG2-1:0]];
                audio_strobe <= 1'b1;
                rd_ptr       <= rd_ptr + ptr_w'(1);
            end
        end
    end

    assign out_wrap = (out_div == out_div_w'(`C2V_AUDIO_OUT_HALF - 1));

    // 48 kHz square wave
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            out_div   <= '0;
            clk_audio <= 1'b0;
        end else begin
            out_div <= out_wrap ? '0 : out_div + out_div_w'(1);
            if (out_wrap) begin
                clk_audio <= ~clk_audio;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/frame_sync.sv */
/* aligns the console frame to the raster once per frame
   pauses the console on line 2 until the first picture line starts */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module frame_sync (
    input  wire                  clk_pixel,
    input  wire                  resetn,
    input  c2v_pkg::raster_pos_t pos,
    input  wire [8:0]            console_line,
    input  wire                  snes_refresh,
    output logic                 pause_console
);

    // first 100 columns of the first picture line
    localparam int first_span = 100;

    c2v_pkg::sync_state_t state;
    logic                 first_line;

    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            first_line <= 1'b0;
        end else begin
            first_line <= (pos.y == 10'(`C2V_PIC_Y0)) &&
                          (pos.x >= 11'(`C2V_PIC_X0)) &&
                          (pos.x < 11'(`C2V_PIC_X0 + first_span));
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            state <= c2v_pkg::sync_running;
        end else begin
            case (state)
                // hold the console during its refresh slot
                c2v_pkg::sync_running:
                    if (console_line[7:0] == 8'(`C2V_SYNC_LINE) && snes_refresh) begin
                        state <= c2v_pkg::sync_paused;
                    end
                // raster caught up, let the console go
                c2v_pkg::sync_paused:
                    if (first_line) begin
                        state <= c2v_pkg::sync_done;
                    end
                // re-arm late in the console frame
                c2v_pkg::sync_done:
                    if (console_line[7:0] == 8'(`C2V_SYNC_CLEAR_LINE)) begin
                        state <= c2v_pkg::sync_running;
                    end
                default:
                    state <= c2v_pkg::sync_running;
            endcase
        end
    end

    assign pause_console = (state == c2v_pkg::sync_paused);

endmodule

`default_nettype wire

/* logic/scale3_readout.sv */
/* 3x scaler from the line buffer onto the 720p raster
   two-cycle pipeline, grey outside the picture, overlay replaces pixels */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module scale3_readout (
    input  wire                  clk_pixel,
    input  wire                  resetn,
    input  c2v_pkg::raster_pos_t pos,
    input  c2v_pkg::rgb15_t      rd_data,
    input  wire                  overlay,
    input  c2v_pkg::rgb15_t      overlay_color,
    output c2v_pkg::buf_addr_t   rd_addr,
    output c2v_pkg::rgb24_t      rgb
);

    c2v_pkg::raster_x_t x_off;
    c2v_pkg::raster_y_t y_off;
    logic [7:0]         console_x;
    logic [7:0]         console_y;
    logic               in_window;
    logic               in_window_q;
    c2v_pkg::rgb15_t    pixel;

    // 5-bit channels to 8 bits, low bits zero, reordered to r/g/b
    function automatic c2v_pkg::rgb24_t expand(input c2v_pkg::rgb15_t c);
        expand = {c[4:0], 3'b000, c[9:5], 3'b000, c[14:10], 3'b000};
    endfunction

    // offset inside the picture, then constant divide by three
    assign x_off     = pos.x - 11'(`C2V_PIC_X0);
    assign y_off     = pos.y - 10'(`C2V_PIC_Y0);
    assign console_x = 8'(x_off / 11'd3);
    assign console_y = 8'(y_off / 10'd3);

    assign in_window = (pos.x >= 11'(`C2V_PIC_X0)) && (pos.x < 11'(`C2V_PIC_X1)) &&
                       (pos.y >= 10'(`C2V_PIC_Y0)) && (pos.y < 10'(`C2V_PIC_Y1));

    // issued in the same cycle as the position
    assign rd_addr = {console_y[`C2V_LINES_LOG2-1:0], console_x};

    // window flag follows the buffer read latency
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            in_window_q <= 1'b0;
        end else begin
            in_window_q <= in_window;
        end
    end

    // overlay sampled alongside the returned buffer word
    assign pixel = overlay ? overlay_color : rd_data;

    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            rgb <= '0;
        end else if (in_window_q) begin
            rgb <= expand(pixel);
        end else begin
            rgb <= `C2V_BORDER;
        end
    end

endmodule

`default_nettype wire

/* logic/dot_capture.sv */
/* turns console dot strobes into line buffer writes
   lines are stored modulo 16, pixels at half the xs resolution */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module dot_capture (
    input  wire                   clk_pixel,
    input  wire                   resetn,
    input  c2v_pkg::console_dot_t dot,
    output logic                  wr_en,
    output c2v_pkg::buf_addr_t    wr_addr,
    output c2v_pkg::rgb15_t       wr_data
);

    logic strobe_q;
    logic strobe_rise;
    logic in_picture;

    // previous strobe level for edge detect
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= dot.strobe;
        end
    end

    assign strobe_rise = dot.strobe & ~strobe_q;

    // only lines the console actually draws, field bit ignored
    assign in_picture = ~dot.hblank & ~dot.vblank &
                        (dot.ys[7:0] < 8'(`C2V_VISIBLE_LINES));

    // write strobe, one cycle after the rising edge
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= strobe_rise & in_picture;
        end
    end

    // address and colour captured with the edge
    always_ff @(posedge clk_pixel) begin
        if (strobe_rise) begin
            // xs counts half dots, so bit 0 is dropped
            wr_addr <= {dot.ys[`C2V_LINES_LOG2-1:0], dot.xs[8:1]};
            wr_data <= dot.color;
        end
    end

endmodule

`default_nettype wire

/* logic/line_ring_buffer.sv */
/* 16-line by 256-pixel console line store, block RAM style
   one write port from capture, one registered read port for readout */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module line_ring_buffer (
    input  wire                clk_pixel,
    input  wire                wr_en,
    input  c2v_pkg::buf_addr_t wr_addr,
    input  c2v_pkg::rgb15_t    wr_data,
    input  c2v_pkg::buf_addr_t rd_addr,
    output c2v_pkg::rgb15_t    rd_data
);

    localparam int depth = 1 << (`C2V_LINES_LOG2 + 8);

    c2v_pkg::rgb15_t mem [0:depth-1];
    c2v_pkg::rgb15_t rd_q;

    // write port
    always_ff @(posedge clk_pixel) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, registered
    // same-address collision gives the old word
    always_ff @(posedge clk_pixel) begin
        rd_q <= mem[rd_addr];
    end

    assign rd_data = rd_q;

endmodule

`default_nettype wire

/* logic/raster_timing.sv */
/* free-running 1650 x 750 raster scan for the 720p output
   the position is the time base for readout and frame sync */
`timescale 1ns/10ps
`default_nettype none

`include "c2v_params.svh"

module raster_timing (
    input  wire                  clk_pixel,
    input  wire                  resetn,
    output c2v_pkg::raster_pos_t pos
);

    c2v_pkg::raster_x_t x_cnt;
    c2v_pkg::raster_y_t y_cnt;
    logic               x_last;
    logic               y_last;

    // end of line and end of frame markers
    assign x_last = (x_cnt == 11'(`C2V_TOTAL_W - 1));
    assign y_last = (y_cnt == 10'(`C2V_TOTAL_H - 1));

    // column counter, one position per clock
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            x_cnt <= '0;
        end else if (x_last) begin
            x_cnt <= '0;
        end else begin
            x_cnt <= x_cnt + 11'd1;
        end
    end

    // line counter only moves on the column wrap
    always_ff @(posedge clk_pixel) begin
        if (resetn) begin
            y_cnt <= '0;
        end else if (x_last) begin
            if (y_last) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 10'd1;
            end
        end
    end

    assign pos.x = x_cnt;
    assign pos.y = y_cnt;

endmodule

`default_nettype wire

/* logic/c2v_pkg.sv */
/* shared types for the console-to-720p video and audio bridge
   every block refers to these by scoped name */
`default_nettype none

package c2v_pkg;

    // console pixel, blue in the top bits, red in the low five
    typedef logic [14:0] rgb15_t;
    // output pixel, red / green / blue, 8 bits each
    typedef logic [23:0] rgb24_t;

    typedef logic [10:0] raster_x_t;
    typedef logic [9:0]  raster_y_t;

    // 4 line bits on top of 8 column bits
    typedef logic [11:0] buf_addr_t;

    typedef logic [15:0] sample_t;

    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_t;

    // console video inputs as seen in the pixel clock domain
    typedef struct packed {
        logic       strobe;
        logic       hblank;
        logic       vblank;
        rgb15_t     color;
        logic [8:0] xs;
        // bit 8 carries the field, low bits the line
        logic [8:0] ys;
    } console_dot_t;

    typedef struct packed {
        raster_x_t x;
        raster_y_t y;
    } raster_pos_t;

    typedef enum logic [1:0] {
        sync_running,
        sync_paused,
        sync_done
    } sync_state_t;

endpackage

`default_nettype wire

/* logic/c2v_params.svh */
/* raster, picture window, buffer and audio divider constants
   include wherever a block needs the frame geometry or the rates */
`ifndef C2V_PARAMS_SVH
`define C2V_PARAMS_SVH

// full 720p frame including blanking
`define C2V_TOTAL_W 1650
`define C2V_TOTAL_H 750

// 3x scaled console picture, 768 x 672
`define C2V_PIC_X0 256
`define C2V_PIC_X1 1024
`define C2V_PIC_Y0 24
`define C2V_PIC_Y1 696

// ring of 16 console lines
`define C2V_LINES_LOG2 4
`define C2V_VISIBLE_LINES 224

// 74.25 MHz pixel clock divided down to ~32 kHz release and 48 kHz clock
`define C2V_AUDIO_IN_DIV 2320
`define C2V_AUDIO_OUT_HALF 773
`define C2V_FIFO_LOG2 2

`define C2V_BORDER 24'h303030

// console lines that trigger and re-arm frame sync
`define C2V_SYNC_LINE 2
`define C2V_SYNC_CLEAR_LINE 200

`endif
